//--- ldg_settings.svh
// ----------------------------------------------------------
// Shared sizes of the GLWE load splitter
// Included by the package and by every RTL file
// ----------------------------------------------------------
`ifndef LDG_SETTINGS_SVH
`define LDG_SETTINGS_SVH

// Coefficient word and beat shape
`define LDG_COEF_W 32
`define LDG_COEF_NB 4

// Write lanes and GLWE RAM banks
`define LDG_LANE_NB 2
`define LDG_GRAM_NB 2

// Row address and per-lane beat count
`define LDG_ADD_W 8
`define LDG_BEAT_W 6

// Pending done pulses per lane before overflow
`define LDG_DONE_DEPTH 8

`endif

//--- ldg_pkg.sv
// ----------------------------------------------------------
// Types shared by the load splitter RTL and its testbench
// ----------------------------------------------------------
`include "ldg_settings.svh"

package ldg_pkg;

  // Bank index width, one bit for two banks
  localparam int GRAM_ID_W = $clog2(`LDG_GRAM_NB);

  typedef logic [`LDG_COEF_W-1:0] coef_t;
  typedef logic [`LDG_ADD_W-1:0]  ram_add_t;
  typedef logic [GRAM_ID_W-1:0]   gram_id_t;
  typedef logic [`LDG_BEAT_W-1:0] beat_cnt_t;

  // Load command, MSB first
  // bank id, then base row, then beats per lane
  typedef logic [GRAM_ID_W+`LDG_ADD_W+`LDG_BEAT_W-1:0] ldg_cmd_t;

  // Write lane FSM
  typedef enum logic [1:0] {
    IDLE,
    WAIT_AVAIL,
    WRITE
  } lane_state_e;

endpackage

//--- ldg_stream_dispatch.sv
// ----------------------------------------------------------
// Deals coefficient beats to the write lanes in turn
// One output register per lane decouples the lane stalls
// ----------------------------------------------------------
`include "ldg_settings.svh"

module ldg_stream_dispatch (
  input  logic                                                clk,
  input  logic                                                s_rst_n,
  input  ldg_pkg::coef_t [`LDG_COEF_NB-1:0]                   in_data_i,
  input  logic                                                in_vld_i,
  output logic                                                in_rdy_o,
  output ldg_pkg::coef_t [`LDG_LANE_NB-1:0][`LDG_COEF_NB-1:0] out_data_o,
  output logic [`LDG_LANE_NB-1:0]                             out_vld_o,
  input  logic [`LDG_LANE_NB-1:0]                             out_rdy_i
);

  localparam int TURN_W = (`LDG_LANE_NB > 1) ? $clog2(`LDG_LANE_NB) : 1;

  logic [TURN_W-1:0] turn;
  logic              in_xfer;

  // Target register empty, or drained this cycle
  assign in_rdy_o = ~out_vld_o[turn] | out_rdy_i[turn];
  assign in_xfer  = in_vld_i & in_rdy_o;

  // ----------------------------------------------------------
  // Turn pointer
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      turn <= '0;
    end else if (in_xfer) begin
      // Wrap after the last lane
      if (turn == TURN_W'(`LDG_LANE_NB - 1)) begin
        turn <= '0;
      end else begin
        turn <= turn + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Lane output registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_vld_o <= '0;
    end else begin
      for (int i = 0; i < `LDG_LANE_NB; i++) begin
        // Fill wins over drain, same entry reloaded
        if (in_xfer && (turn == TURN_W'(i))) begin
          out_vld_o[i] <= 1'b1;
        end else if (out_rdy_i[i]) begin
          out_vld_o[i] <= 1'b0;
        end
      end
    end
  end

  // Beat payload, only the target lane loads
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      out_data_o[turn] <= in_data_i;
    end
  end

  // Held beat stays put until its lane takes it
  for (genvar gi = 0; gi < `LDG_LANE_NB; gi++) begin : gen_hold_chk
    a_out_hold: assert property (@(posedge clk) disable iff (!s_rst_n)
      out_vld_o[gi] && !out_rdy_i[gi] |=> out_vld_o[gi] && $stable(out_data_o[gi]))
      else $error("dispatch lane %0d changed a stalled beat", gi);
  end

endmodule

//--- ldg_lane_write.sv
// ----------------------------------------------------------
// One write lane: takes a command, waits for its bank,
// then writes its beats into successive rows of that bank
// ----------------------------------------------------------
`include "ldg_settings.svh"

module ldg_lane_write #(
  parameter int IN_DLY = 0
) (
  input  logic                              clk,
  input  logic                              s_rst_n,
  input  logic [`LDG_GRAM_NB-1:0]           garb_ldg_avail_1h_i,
  input  ldg_pkg::ldg_cmd_t                 cmd_i,
  input  logic                              cmd_vld_i,
  output logic                              cmd_rdy_o,
  output logic                              done_o,
  input  ldg_pkg::coef_t [`LDG_COEF_NB-1:0] in_data_i,
  input  logic                              in_vld_i,
  output logic                              in_rdy_o,
  output logic                              wr_en_o,
  output ldg_pkg::gram_id_t                 wr_gram_o,
  output ldg_pkg::ram_add_t                 wr_add_o,
  output ldg_pkg::coef_t [`LDG_COEF_NB-1:0] wr_data_o,
  output logic                              busy_o
);
  import ldg_pkg::*;

  // Write pipe depth, lane 1 adds a stage to stagger bank ports
  localparam int PIPE_D = 1 + IN_DLY;

  lane_state_e state;
  lane_state_e state_nxt;

  // Command fields
  gram_id_t  cmd_gram;
  ram_add_t  cmd_base;
  beat_cnt_t cmd_beats;

  // Latched command and progress
  gram_id_t  bank_q;
  ram_add_t  add_q;
  beat_cnt_t beats_q;
  beat_cnt_t cnt;

  logic avail;
  logic in_xfer;
  logic in_last;

  logic     [PIPE_D-1:0]                   en_p;
  logic     [PIPE_D-1:0]                   last_p;
  ram_add_t [PIPE_D-1:0]                   add_p;
  coef_t    [PIPE_D-1:0][`LDG_COEF_NB-1:0] data_p;

  assign {cmd_gram, cmd_base, cmd_beats} = cmd_i;

  assign avail     = garb_ldg_avail_1h_i[bank_q];
  assign cmd_rdy_o = (state == IDLE);
  assign busy_o    = (state != IDLE);

  // No more beats once the whole share is in
  assign in_rdy_o = (state == WRITE) && avail && (cnt != beats_q);
  assign in_xfer  = in_vld_i && in_rdy_o;
  assign in_last  = (beat_cnt_t'(cnt + 1'b1) == beats_q);

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:       if (cmd_vld_i) state_nxt = WAIT_AVAIL;
      WAIT_AVAIL: if (avail) state_nxt = WRITE;
      WRITE:      if (!avail) state_nxt = WAIT_AVAIL;
      default:    state_nxt = IDLE;
    endcase
    // Command ends with the done pulse, writes all flushed
    if (done_o) begin
      state_nxt = IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (cmd_vld_i && cmd_rdy_o) begin
        cnt <= '0;
      end else if (in_xfer) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Command fields and row pointer
  always_ff @(posedge clk) begin
    if (cmd_vld_i && cmd_rdy_o) begin
      bank_q  <= cmd_gram;
      beats_q <= cmd_beats;
      add_q   <= cmd_base;
    end else if (in_xfer) begin
      add_q <= add_q + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Write pipe
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      en_p   <= '0;
      done_o <= 1'b0;
    end else begin
      en_p[0] <= in_xfer;
      for (int k = 1; k < PIPE_D; k++) begin
        en_p[k] <= en_p[k-1];
      end
      done_o <= en_p[PIPE_D-1] && last_p[PIPE_D-1];
    end
  end

  always_ff @(posedge clk) begin
    last_p[0] <= in_last;
    add_p[0]  <= add_q;
    data_p[0] <= in_data_i;
    for (int k = 1; k < PIPE_D; k++) begin
      last_p[k] <= last_p[k-1];
      add_p[k]  <= add_p[k-1];
      data_p[k] <= data_p[k-1];
    end
  end

  // Bank is fixed until done, so no need to pipe it
  assign wr_en_o   = en_p[PIPE_D-1];
  assign wr_gram_o = bank_q;
  assign wr_add_o  = add_p[PIPE_D-1];
  assign wr_data_o = data_p[PIPE_D-1];

  a_no_idle_wr: assert property (@(posedge clk) disable iff (!s_rst_n)
    wr_en_o |-> state != IDLE)
    else $error("lane write while idle");

endmodule

//--- ldg_done_fifo.sv
// ----------------------------------------------------------
// Counted queue of done pulses with valid/ready output
// Pulses are never held back, overflow raises a sticky error
// ----------------------------------------------------------
`include "ldg_settings.svh"

module ldg_done_fifo (
  input  logic clk,
  input  logic s_rst_n,
  input  logic in_pulse_i,
  output logic out_vld_o,
  input  logic out_rdy_i,
  output logic error_o
);

  localparam int CNT_W = $clog2(`LDG_DONE_DEPTH + 1);

  logic [CNT_W-1:0] occ;
  logic             pop;
  logic             full;

  assign pop       = out_vld_o & out_rdy_i;
  assign full      = (occ == CNT_W'(`LDG_DONE_DEPTH));
  assign out_vld_o = (occ != '0);

  // ----------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      occ <= '0;
    end else begin
      case ({in_pulse_i, pop})
        2'b10: begin
          // Lost pulse when full
          if (!full) begin
            occ <= occ + 1'b1;
          end
        end
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
    end
  end

  // Sticky overflow
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      error_o <= 1'b0;
    end else if (in_pulse_i && full && !pop) begin
      error_o <= 1'b1;
    end
  end

endmodule

//--- ldg_splitc_core.sv
// ----------------------------------------------------------
// Load splitter core: forks commands to the lanes, deals the
// data beats and joins the lane done queues into one strobe
// ----------------------------------------------------------
`include "ldg_settings.svh"

module ldg_splitc_core (
  input  logic                                                clk,
  input  logic                                                s_rst_n,
  input  logic [`LDG_GRAM_NB-1:0]                             garb_ldg_avail_1h_i,
  input  ldg_pkg::ldg_cmd_t                                   cmd_i,
  input  logic                                                cmd_vld_i,
  output logic                                                cmd_rdy_o,
  output logic                                                cmd_done_o,
  input  ldg_pkg::coef_t [`LDG_COEF_NB-1:0]                   data_i,
  input  logic                                                data_vld_i,
  output logic                                                data_rdy_o,
  output logic [`LDG_LANE_NB-1:0]                             wr_en_o,
  output ldg_pkg::gram_id_t [`LDG_LANE_NB-1:0]                wr_gram_o,
  output ldg_pkg::ram_add_t [`LDG_LANE_NB-1:0]                wr_add_o,
  output ldg_pkg::coef_t [`LDG_LANE_NB-1:0][`LDG_COEF_NB-1:0] wr_data_o,
  output logic [`LDG_LANE_NB-1:0]                             lane_busy_o,
  output logic                                                error_o
);
  import ldg_pkg::*;

  logic [`LDG_LANE_NB-1:0] lane_cmd_vld;
  logic [`LDG_LANE_NB-1:0] lane_cmd_rdy;
  logic [`LDG_LANE_NB-1:0] lane_done;

  coef_t [`LDG_LANE_NB-1:0][`LDG_COEF_NB-1:0] lane_data;
  logic  [`LDG_LANE_NB-1:0]                   lane_data_vld;
  logic  [`LDG_LANE_NB-1:0]                   lane_data_rdy;

  logic [`LDG_LANE_NB-1:0] done_vld;
  logic [`LDG_LANE_NB-1:0] done_rdy;
  logic [`LDG_LANE_NB-1:0] done_err;

  // ----------------------------------------------------------
  // Command fork
  // ----------------------------------------------------------
  assign cmd_rdy_o = &lane_cmd_rdy;

  // Lane sees valid only when all the others are ready
  always_comb begin
    for (int i = 0; i < `LDG_LANE_NB; i++) begin
      lane_cmd_vld[i] = cmd_vld_i;
      for (int j = 0; j < `LDG_LANE_NB; j++) begin
        if (j != i) begin
          lane_cmd_vld[i] &= lane_cmd_rdy[j];
        end
      end
    end
  end

  // Data dealer
  ldg_stream_dispatch u_dispatch (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .in_data_i  (data_i),
    .in_vld_i   (data_vld_i),
    .in_rdy_o   (data_rdy_o),
    .out_data_o (lane_data),
    .out_vld_o  (lane_data_vld),
    .out_rdy_i  (lane_data_rdy)
  );

  // ----------------------------------------------------------
  // Lanes and their done queues
  // ----------------------------------------------------------
  for (genvar gi = 0; gi < `LDG_LANE_NB; gi++) begin : gen_lane
    ldg_lane_write #(
      .IN_DLY (gi % 2)
    ) u_lane (
      .clk                 (clk),
      .s_rst_n             (s_rst_n),
      .garb_ldg_avail_1h_i (garb_ldg_avail_1h_i),
      .cmd_i               (cmd_i),
      .cmd_vld_i           (lane_cmd_vld[gi]),
      .cmd_rdy_o           (lane_cmd_rdy[gi]),
      .done_o              (lane_done[gi]),
      .in_data_i           (lane_data[gi]),
      .in_vld_i            (lane_data_vld[gi]),
      .in_rdy_o            (lane_data_rdy[gi]),
      .wr_en_o             (wr_en_o[gi]),
      .wr_gram_o           (wr_gram_o[gi]),
      .wr_add_o            (wr_add_o[gi]),
      .wr_data_o           (wr_data_o[gi]),
      .busy_o              (lane_busy_o[gi])
    );

    ldg_done_fifo u_done_fifo (
      .clk        (clk),
      .s_rst_n    (s_rst_n),
      .in_pulse_i (lane_done[gi]),
      .out_vld_o  (done_vld[gi]),
      .out_rdy_i  (done_rdy[gi]),
      .error_o    (done_err[gi])
    );
  end

  // ----------------------------------------------------------
  // Done join and error
  // ----------------------------------------------------------
  // All queues pop together once every lane is through
  assign done_rdy = {`LDG_LANE_NB{&done_vld}};

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      cmd_done_o <= 1'b0;
      error_o    <= 1'b0;
    end else begin
      cmd_done_o <= &done_vld;
      error_o    <= |done_err;
    end
  end

  // Lanes drifted further apart than the done queues hold
  a_no_overflow: assert property (@(posedge clk) disable iff (!s_rst_n) !error_o)
    else $error("done queue overflow");

endmodule

//--- ldg_glwe_ram.sv
// ----------------------------------------------------------
// Behavioral two-bank GLWE RAM, one row slice per lane
// Single synchronous read port for checking the contents
// ----------------------------------------------------------
`include "ldg_settings.svh"

module ldg_glwe_ram (
  input  logic                                                clk,
  input  logic [`LDG_LANE_NB-1:0]                             wr_en_i,
  input  ldg_pkg::gram_id_t [`LDG_LANE_NB-1:0]                wr_gram_i,
  input  ldg_pkg::ram_add_t [`LDG_LANE_NB-1:0]                wr_add_i,
  input  ldg_pkg::coef_t [`LDG_LANE_NB-1:0][`LDG_COEF_NB-1:0] wr_data_i,
  input  ldg_pkg::gram_id_t                                   rd_gram_i,
  input  ldg_pkg::ram_add_t                                   rd_add_i,
  output ldg_pkg::coef_t [`LDG_LANE_NB*`LDG_COEF_NB-1:0]      rd_data_o
);
  import ldg_pkg::*;

  // Row holds lane 0 coefficients at the bottom
  coef_t [`LDG_LANE_NB-1:0][`LDG_COEF_NB-1:0] mem [`LDG_GRAM_NB][2**`LDG_ADD_W];

  // Lanes own disjoint slices, so writes never collide
  always_ff @(posedge clk) begin
    for (int l = 0; l < `LDG_LANE_NB; l++) begin
      if (wr_en_i[l]) begin
        mem[wr_gram_i[l]][wr_add_i[l]][l] <= wr_data_i[l];
      end
    end
  end

  // Registered read
  always_ff @(posedge clk) begin
    rd_data_o <= mem[rd_gram_i][rd_add_i];
  end

endmodule

//--- ldg_top.sv
// ----------------------------------------------------------
// Load splitter top: core plus GLWE RAM
// ----------------------------------------------------------
`include "ldg_settings.svh"

module ldg_top (
  input  logic                                           clk,
  input  logic                                           s_rst_n,
  input  logic [`LDG_GRAM_NB-1:0]                        garb_ldg_avail_1h_i,
  input  ldg_pkg::ldg_cmd_t                              cmd_i,
  input  logic                                           cmd_vld_i,
  output logic                                           cmd_rdy_o,
  output logic                                           cmd_done_o,
  input  ldg_pkg::coef_t [`LDG_COEF_NB-1:0]              data_i,
  input  logic                                           data_vld_i,
  output logic                                           data_rdy_o,
  input  ldg_pkg::gram_id_t                              rd_gram_i,
  input  ldg_pkg::ram_add_t                              rd_add_i,
  output ldg_pkg::coef_t [`LDG_LANE_NB*`LDG_COEF_NB-1:0] rd_data_o,
  output logic [`LDG_LANE_NB-1:0]                        lane_busy_o,
  output logic                                           error_o
);
  import ldg_pkg::*;

  // Lane write ports
  logic     [`LDG_LANE_NB-1:0]                   wr_en;
  gram_id_t [`LDG_LANE_NB-1:0]                   wr_gram;
  ram_add_t [`LDG_LANE_NB-1:0]                   wr_add;
  coef_t    [`LDG_LANE_NB-1:0][`LDG_COEF_NB-1:0] wr_data;

  ldg_splitc_core u_core (
    .clk                 (clk),
    .s_rst_n             (s_rst_n),
    .garb_ldg_avail_1h_i (garb_ldg_avail_1h_i),
    .cmd_i               (cmd_i),
    .cmd_vld_i           (cmd_vld_i),
    .cmd_rdy_o           (cmd_rdy_o),
    .cmd_done_o          (cmd_done_o),
    .data_i              (data_i),
    .data_vld_i          (data_vld_i),
    .data_rdy_o          (data_rdy_o),
    .wr_en_o             (wr_en),
    .wr_gram_o           (wr_gram),
    .wr_add_o            (wr_add),
    .wr_data_o           (wr_data),
    .lane_busy_o         (lane_busy_o),
    .error_o             (error_o)
  );

  ldg_glwe_ram u_ram (
    .clk       (clk),
    .wr_en_i   (wr_en),
    .wr_gram_i (wr_gram),
    .wr_add_i  (wr_add),
    .wr_data_i (wr_data),
    .rd_gram_i (rd_gram_i),
    .rd_add_i  (rd_add_i),
    .rd_data_o (rd_data_o)
  );

endmodule

//--- tb_ldg_top.sv
// ----------------------------------------------------------
// Testbench for the load splitter top level
// Drives load commands and beats, checks RAM rows vs a model
// ----------------------------------------------------------
`include "ldg_settings.svh"

module tb_ldg_top;
  timeunit 1ns;
  timeprecision 100ps;
  import ldg_pkg::*;

  // Limit for the whole run, wide margin over all tests
  localparam int MAX_CYCLES = 4000;
  localparam int ROW_NB     = 2**`LDG_ADD_W;

  typedef coef_t [`LDG_COEF_NB-1:0]              beat_t;
  typedef coef_t [`LDG_LANE_NB*`LDG_COEF_NB-1:0] row_t;

  logic                    clk;
  logic                    s_rst_n;
  logic [`LDG_GRAM_NB-1:0] garb_ldg_avail_1h_i;
  ldg_cmd_t                cmd_i;
  logic                    cmd_vld_i;
  logic                    cmd_rdy_o;
  logic                    cmd_done_o;
  beat_t                   data_i;
  logic                    data_vld_i;
  logic                    data_rdy_o;
  gram_id_t                rd_gram_i;
  ram_add_t                rd_add_i;
  row_t                    rd_data_o;
  logic [`LDG_LANE_NB-1:0] lane_busy_o;
  logic                    error_o;

  // Model: recorded commands and all their beats
  int    cmd_bank  [64];
  int    cmd_base  [64];
  int    cmd_beats [64];
  int    cmd_first [64];
  beat_t beat_mem  [1024];

  int     cmd_cnt     = 0;
  int     beat_total  = 0;
  int     done_cnt    = 0;
  int     checked_cnt = 0;
  int     err_cnt     = 0;
  int     test_err    = 0;
  int     checks      = 0;
  int     pass_cnt    = 0;
  int     fail_cnt    = 0;
  int     cycles      = 0;
  integer seed;

  ldg_top DUT (
    .clk                 (clk),
    .s_rst_n             (s_rst_n),
    .garb_ldg_avail_1h_i (garb_ldg_avail_1h_i),
    .cmd_i               (cmd_i),
    .cmd_vld_i           (cmd_vld_i),
    .cmd_rdy_o           (cmd_rdy_o),
    .cmd_done_o          (cmd_done_o),
    .data_i              (data_i),
    .data_vld_i          (data_vld_i),
    .data_rdy_o          (data_rdy_o),
    .rd_gram_i           (rd_gram_i),
    .rd_add_i            (rd_add_i),
    .rd_data_o           (rd_data_o),
    .lane_busy_o         (lane_busy_o),
    .error_o             (error_o)
  );

  always #2 clk = ~clk;

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  // Next drive point, 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic flag_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // Expected row from the first upto commands, later ones win
  function automatic row_t ref_row(input int bank, input int add, input int upto);
    row_t row;
    int   r;
    row = 'x;
    for (int k = 0; k < upto; k++) begin
      if (cmd_bank[k] == bank) begin
        for (int n = 0; n < `LDG_LANE_NB * cmd_beats[k]; n++) begin
          // Beat n to lane n mod lanes, row base + n div lanes
          r = (cmd_base[k] + n / `LDG_LANE_NB) % ROW_NB;
          if (r == add) begin
            row[(n % `LDG_LANE_NB)*`LDG_COEF_NB +: `LDG_COEF_NB] = beat_mem[cmd_first[k] + n];
          end
        end
      end
    end
    return row;
  endfunction

  task automatic read_row(input int bank, input int add, output row_t row);
    step();
    rd_gram_i = gram_id_t'(bank);
    rd_add_i  = ram_add_t'(add);
    // RAM registers the row on the next edge
    @(posedge clk);
    @(negedge clk);
    row = rd_data_o;
  endtask

  task automatic check_rows(input int bank, input int base, input int nb, input int upto);
    row_t got;
    row_t exp;
    int   add;
    for (int r = 0; r < nb; r++) begin
      add = (base + r) % ROW_NB;
      read_row(bank, add, got);
      exp = ref_row(bank, add, upto);
      checks++;
      if (got !== exp) begin
        flag_error($sformatf("bank %0d row %0d got %h exp %h", bank, add, got, exp));
      end
    end
  endtask

  // Records a command with fresh beats, then drives it and its data
  task automatic run_cmd(input int bank, input int base, input int beats, input bit gaps);
    int k;
    k = cmd_cnt;
    cmd_bank[k]  = bank;
    cmd_base[k]  = base;
    cmd_beats[k] = beats;
    cmd_first[k] = beat_total;
    for (int n = 0; n < `LDG_LANE_NB * beats; n++) begin
      for (int c = 0; c < `LDG_COEF_NB; c++) begin
        beat_mem[beat_total + n][c] = $random(seed);
      end
    end
    beat_total += `LDG_LANE_NB * beats;
    cmd_cnt++;
    // Command handshake, ready sampled mid-cycle
    cmd_i     = {gram_id_t'(bank), ram_add_t'(base), beat_cnt_t'(beats)};
    cmd_vld_i = 1'b1;
    @(negedge clk);
    while (!cmd_rdy_o) begin
      @(negedge clk);
    end
    step();
    cmd_vld_i = 1'b0;
    for (int n = 0; n < `LDG_LANE_NB * beats; n++) begin
      if (gaps) begin
        repeat (rand_below(3)) step();
      end
      data_i     = beat_mem[cmd_first[k] + n];
      data_vld_i = 1'b1;
      @(negedge clk);
      while (!data_rdy_o) begin
        @(negedge clk);
      end
      step();
      data_vld_i = 1'b0;
    end
  endtask

  task automatic wait_checked(input int n);
    while (checked_cnt < n) begin
      step();
    end
  endtask

  // Settle, then the checks shared by every test and its line
  task automatic end_test(input string name);
    repeat (10) step();
    if (done_cnt != cmd_cnt) begin
      flag_error($sformatf("%0d done strobes for %0d commands", done_cnt, cmd_cnt));
    end
    if (error_o !== 1'b0) begin
      flag_error("error_o raised");
    end
    if (lane_busy_o !== '0) begin
      flag_error("lanes still busy after the command");
    end
    if (err_cnt == test_err) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - test_err);
    end
    test_err = err_cnt;
  endtask

  // ----------------------------------------------------------
  // Done counting, compare and watchdog
  // ----------------------------------------------------------
  always @(negedge clk) begin
    if (s_rst_n && cmd_done_o) begin
      done_cnt++;
      if (done_cnt > cmd_cnt) begin
        $display("Done strobe at %0t with no command outstanding", $time);
        err_cnt++;
      end
    end
  end

  // Commands finish in order, rows checked one command at a time
  initial begin
    forever begin
      @(posedge clk);
      if (done_cnt > checked_cnt) begin
        check_rows(cmd_bank[checked_cnt], cmd_base[checked_cnt],
                   cmd_beats[checked_cnt], checked_cnt + 1);
        checked_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles, DUT did not finish", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin
    int target;
    seed                = 4;
    clk                 = 1'b0;
    s_rst_n             = 1'b0;
    garb_ldg_avail_1h_i = '1;
    cmd_i               = '0;
    cmd_vld_i           = 1'b0;
    data_i              = '0;
    data_vld_i          = 1'b0;
    rd_gram_i           = '0;
    rd_add_i            = '0;
    repeat (3) @(posedge clk);
    #1;
    s_rst_n = 1'b1;

    // Idle outputs after reset
    @(negedge clk);
    if (cmd_done_o !== 1'b0 || error_o !== 1'b0 || lane_busy_o !== '0) begin
      flag_error("status outputs not low after reset");
    end
    if (cmd_rdy_o !== 1'b1) begin
      flag_error("cmd_rdy_o not high after reset");
    end
    step();
    end_test("reset state");

    run_cmd(0, 0, 8, 1'b0);
    wait_checked(cmd_cnt);
    end_test("single bank 0 command");

    // Only bank 0 available, bank 1 command must stall
    garb_ldg_avail_1h_i = 2'b01;
    fork
      run_cmd(1, 10, 6, 1'b0);
      begin
        repeat (20) step();
        @(negedge clk);
        if (lane_busy_o !== '1 || data_rdy_o !== 1'b0) begin
          flag_error("stalled lanes not busy or data still accepted");
        end
        if (done_cnt != cmd_cnt - 1) begin
          flag_error("done strobe while bank withheld");
        end
        check_rows(1, 10, 6, cmd_cnt - 1);
        step();
        garb_ldg_avail_1h_i = '1;
      end
    join
    wait_checked(cmd_cnt);
    end_test("withheld bank 1");

    // Alternating banks, rows kept apart per command
    for (int k = 0; k < 6; k++) begin
      run_cmd(k % 2, 100 + 20 * k, 4 + rand_below(8), 1'b1);
    end
    wait_checked(cmd_cnt);
    end_test("back to back commands");

    // Bank 0 availability flips at random until done
    target = cmd_cnt + 1;
    fork
      run_cmd(0, 200, 40, 1'b1);
      begin
        while (done_cnt < target) begin
          step();
          garb_ldg_avail_1h_i[0] = (rand_below(2) == 1);
        end
        garb_ldg_avail_1h_i = '1;
      end
    join
    wait_checked(cmd_cnt);
    end_test("toggled availability");

    $display("%0d tests, %0d passed, %0d failed, %0d row checks, %0d errors",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, checks, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+.
ldg_pkg.sv
ldg_stream_dispatch.sv
ldg_lane_write.sv
ldg_done_fifo.sv
ldg_splitc_core.sv
ldg_glwe_ram.sv
ldg_top.sv
tb_ldg_top.sv
